// File: ce_cfg.svh
`ifndef CE_CFG_SVH
`define CE_CFG_SVH

// Data path widths
`define CE_DATA_W       64
`define CE_ADDR_W       64
`define CE_SIZE_W       16

// Tags count up from zero and wrap
`define CE_TAG_W        8

// Buffer depth, also the read credit limit
`define CE_BUF_DEPTH    8

// Register bus
`define CE_CSR_ADDR_W   4

// Feature identification
`define CE_FEAT_ID      12'h001
`define CE_FEAT_VER     4'h1

`endif

// File: ce_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "ce_cfg.svh"

module ce_chk (
   input wire logic               clk,
   input wire logic               arst_n,
   input wire logic               csr_ren,
   input wire logic               csr_rvalid,
   input wire logic               rdreq_valid,
   input wire logic               rdreq_ready,
   input wire ce_xfer_pkg::addr_t rdreq_addr,
   input wire ce_xfer_pkg::tag_t  rdreq_tag,
   input wire logic               wr_valid,
   input wire logic               wr_ready,
   input wire ce_xfer_pkg::addr_t wr_addr,
   input wire ce_xfer_pkg::word_t wr_data,
   input wire logic               buf_pop
);

   // Requests accepted but not yet popped from the buffer
   int inflight;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         inflight <= 0;
      end else begin
         inflight <= inflight + int'(rdreq_valid && rdreq_ready) - int'(buf_pop);
      end
   end

   a_rdreq_hold: assert property (@(posedge clk) disable iff (!arst_n)
      rdreq_valid && !rdreq_ready |=> rdreq_valid && $stable(rdreq_addr) && $stable(rdreq_tag))
      else $error("read request dropped or changed before ready");

   a_wr_hold: assert property (@(posedge clk) disable iff (!arst_n)
      wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data))
      else $error("write dropped or changed before ready");

   a_rvalid: assert property (@(posedge clk) disable iff (!arst_n)
      csr_rvalid == $past(csr_ren))
      else $error("register read valid not one cycle after read strobe");

   a_credit: assert property (@(posedge clk) disable iff (!arst_n)
      inflight <= `CE_BUF_DEPTH)
      else $error("outstanding plus buffered words exceed buffer depth");

endmodule

bind ce_top ce_chk u_chk (
   .clk         (clk),
   .arst_n      (arst_n),
   .csr_ren     (csr_ren),
   .csr_rvalid  (csr_rvalid),
   .rdreq_valid (rdreq_valid),
   .rdreq_ready (rdreq_ready),
   .rdreq_addr  (rdreq_addr),
   .rdreq_tag   (rdreq_tag),
   .wr_valid    (wr_valid),
   .wr_ready    (wr_ready),
   .wr_addr     (wr_addr),
   .wr_data     (wr_data),
   .buf_pop     (buf_pop)
);

`default_nettype wire

// File: ce_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Transfer command from the register block to both engines
interface ce_cmd_if;

   logic               start;
   ce_xfer_pkg::addr_t host_addr;
   ce_xfer_pkg::addr_t hps_addr;
   ce_xfer_pkg::size_t size;

   modport csr (
      output start,
      output host_addr,
      output hps_addr,
      output size
   );

   modport rd (input start, input host_addr, input size);

   modport wr (input start, input hps_addr, input size);

endinterface

`default_nettype wire

// File: ce_cpl_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "ce_cfg.svh"

module ce_cpl_rx (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               first_tag_rst,
   input  logic               cpl_valid,
   input  ce_xfer_pkg::word_t cpl_data,
   input  ce_xfer_pkg::tag_t  cpl_tag,
   input  logic               cpl_err_in,
   input  logic               buf_pop,
   output ce_xfer_pkg::word_t buf_data,
   output logic               buf_not_empty,
   output logic               cpl_err,
   output logic               tag_err
);

   typedef logic [$clog2(`CE_BUF_DEPTH)-1:0] ptr_t;
   typedef logic [$clog2(`CE_BUF_DEPTH):0]   cnt_t;

   ce_xfer_pkg::word_t mem [`CE_BUF_DEPTH];
   ptr_t               wr_ptr;
   ptr_t               rd_ptr;
   cnt_t               count;
   ce_xfer_pkg::tag_t  exp_tag;
   logic               pop;

   // ------------------------------
   // Tag and error tracking
   // ------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exp_tag <= '0;
         tag_err <= 1'b0;
         cpl_err <= 1'b0;
      end else if (first_tag_rst) begin
         exp_tag <= '0;
         tag_err <= 1'b0;
         cpl_err <= 1'b0;
      end else if (cpl_valid) begin
         exp_tag <= exp_tag + 1'b1;
         if (cpl_tag != exp_tag) begin
            tag_err <= 1'b1;
         end
         if (cpl_err_in) begin
            cpl_err <= 1'b1;
         end
      end
   end

   // ------------------------------
   // Circular data buffer
   // ------------------------------

   // No full check, credits keep the buffer from overflowing
   assign pop           = buf_pop && buf_not_empty;
   assign buf_not_empty = (count != '0);
   assign buf_data      = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (cpl_valid) begin
         mem[wr_ptr] <= cpl_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (cpl_valid) begin
            wr_ptr <= (wr_ptr == ptr_t'(`CE_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_t'(`CE_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({cpl_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: ce_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "ce_cfg.svh"

module ce_csr (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  csr_wen,
   input  logic                  csr_ren,
   input  ce_reg_pkg::csr_addr_e csr_addr,
   input  ce_xfer_pkg::word_t    csr_wdata,
   output ce_xfer_pkg::word_t    csr_rdata,
   output logic                  csr_rvalid,
   input  logic                  cpl_err,
   input  logic                  tag_err,
   input  logic                  wr_err,
   input  logic                  done,
   input  logic                  busy,
   ce_cmd_if.csr                 cmd
);

   ce_xfer_pkg::addr_t  host_addr_q;
   ce_xfer_pkg::addr_t  hps_addr_q;
   ce_xfer_pkg::size_t  size_q;
   ce_reg_pkg::status_t status;
   ce_xfer_pkg::word_t  rd_mux;

   // ------------------------------
   // Programmed command
   // ------------------------------

   // Held while a transfer runs
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         host_addr_q <= '0;
         hps_addr_q  <= '0;
         size_q      <= '0;
      end else if (csr_wen && !busy) begin
         case (csr_addr)
            ce_reg_pkg::HOST_ADDR: host_addr_q <= csr_wdata;
            ce_reg_pkg::HPS_ADDR:  hps_addr_q  <= csr_wdata;
            ce_reg_pkg::SIZE:      size_q      <= csr_wdata[`CE_SIZE_W-1:0];
            default: ;
         endcase
      end
   end

   // Start pulse in the CTRL write cycle, dropped while busy
   assign cmd.start = csr_wen && (csr_addr == ce_reg_pkg::CTRL) && csr_wdata[0] && !busy;

   assign cmd.host_addr = host_addr_q;
   assign cmd.hps_addr  = hps_addr_q;
   assign cmd.size      = size_q;

   // ------------------------------
   // Status and read back
   // ------------------------------

   assign status.busy    = busy;
   assign status.done    = done;
   assign status.cpl_err = cpl_err;
   assign status.wr_err  = wr_err;
   assign status.tag_err = tag_err;

   always_comb begin
      case (csr_addr)
         ce_reg_pkg::ID:        rd_mux = ce_xfer_pkg::word_t'({`CE_FEAT_VER, `CE_FEAT_ID});
         ce_reg_pkg::HOST_ADDR: rd_mux = host_addr_q;
         ce_reg_pkg::HPS_ADDR:  rd_mux = hps_addr_q;
         ce_reg_pkg::SIZE:      rd_mux = ce_xfer_pkg::word_t'(size_q);
         ce_reg_pkg::STATUS:    rd_mux = ce_xfer_pkg::word_t'(status);
         // CTRL is write only, unmapped reads zero
         default:               rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         csr_rvalid <= 1'b0;
      end else begin
         csr_rvalid <= csr_ren;
      end
   end

   always_ff @(posedge clk) begin
      if (csr_ren) begin
         csr_rdata <= rd_mux;
      end
   end

endmodule

`default_nettype wire

// File: ce_rd_req.sv
`timescale 1ns/1ps
`default_nettype none

`include "ce_cfg.svh"

module ce_rd_req (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               rdreq_ready,
   input  logic               buf_pop,
   output logic               rdreq_valid,
   output ce_xfer_pkg::addr_t rdreq_addr,
   output ce_xfer_pkg::tag_t  rdreq_tag,
   output logic               first_tag_rst,
   ce_cmd_if.rd               cmd
);

   typedef logic [$clog2(`CE_BUF_DEPTH):0] credit_t;

   ce_xfer_pkg::rd_state_e state;
   ce_xfer_pkg::size_t     issued;
   credit_t                credit;
   credit_t                credit_nxt;
   logic                   take;

   assign rdreq_valid   = (state == ce_xfer_pkg::RD_ISSUE);
   assign take          = rdreq_valid && rdreq_ready;
   assign rdreq_addr    = cmd.host_addr + (ce_xfer_pkg::addr_t'(issued) << 3);
   assign rdreq_tag     = issued[`CE_TAG_W-1:0];
   // Receiver restarts its expected tag with us
   assign first_tag_rst = cmd.start;

   // One credit per accepted request, one back per buffer pop
   always_comb begin
      credit_nxt = credit;
      if (take) begin
         credit_nxt = credit_nxt - 1'b1;
      end
      if (buf_pop) begin
         credit_nxt = credit_nxt + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= ce_xfer_pkg::RD_IDLE;
         issued <= '0;
         credit <= credit_t'(`CE_BUF_DEPTH);
      end else begin
         credit <= credit_nxt;
         case (state)
            ce_xfer_pkg::RD_IDLE: begin
               if (cmd.start) begin
                  issued <= '0;
                  if (cmd.size != '0) begin
                     state <= ce_xfer_pkg::RD_ISSUE;
                  end
               end
            end
            ce_xfer_pkg::RD_ISSUE: begin
               if (take) begin
                  issued <= issued + 1'b1;
                  if (issued + 1'b1 == cmd.size) begin
                     state <= ce_xfer_pkg::RD_IDLE;
                  end else if (credit_nxt == '0) begin
                     state <= ce_xfer_pkg::RD_WAIT_CREDIT;
                  end
               end
            end
            ce_xfer_pkg::RD_WAIT_CREDIT: begin
               if (credit != '0) begin
                  state <= ce_xfer_pkg::RD_ISSUE;
               end
            end
            default: state <= ce_xfer_pkg::RD_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: ce_reg_pkg.sv
`default_nettype none

`include "ce_cfg.svh"

package ce_reg_pkg;

   // Register word addresses
   typedef enum logic [`CE_CSR_ADDR_W-1:0] {
      ID        = 0,
      HOST_ADDR = 1,
      HPS_ADDR  = 2,
      SIZE      = 3,
      CTRL      = 4,
      STATUS    = 5
   } csr_addr_e;

   // Status word, busy in bit 0
   typedef struct packed {
      logic tag_err;
      logic wr_err;
      logic cpl_err;
      logic done;
      logic busy;
   } status_t;

endpackage

`default_nettype wire

// File: ce_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ce_cfg.svh"

module ce_tb;

   // Words copied over all tests, sets the timeout
   localparam int TOTAL_WORDS = 20 + 37 + 12 + 12 + 12 + 12 + 4 + 16;
   localparam int CYCLE_LIMIT = 60 * TOTAL_WORDS + 2000;

   logic                      clk = 1'b0;
   logic                      arst_n = 1'b0;
   logic                      csr_wen = 1'b0;
   logic                      csr_ren = 1'b0;
   logic [`CE_CSR_ADDR_W-1:0] csr_addr = '0;
   ce_xfer_pkg::word_t        csr_wdata = '0;
   ce_xfer_pkg::word_t        csr_rdata;
   logic                      csr_rvalid;
   logic                      rdreq_valid;
   logic                      rdreq_ready = 1'b0;
   ce_xfer_pkg::addr_t        rdreq_addr;
   ce_xfer_pkg::tag_t         rdreq_tag;
   logic                      cpl_valid = 1'b0;
   ce_xfer_pkg::word_t        cpl_data = '0;
   ce_xfer_pkg::tag_t         cpl_tag = '0;
   logic                      cpl_err = 1'b0;
   logic                      wr_valid;
   logic                      wr_ready = 1'b0;
   ce_xfer_pkg::addr_t        wr_addr;
   ce_xfer_pkg::word_t        wr_data;
   logic                      wr_resp_valid = 1'b0;
   logic                      wr_resp_err = 1'b0;

   logic [31:0] lfsr_q = 32'h88f9;
   int          cycle_cnt = 0;
   logic        stall_en = 1'b0;
   int          cpl_err_at = -1;
   int          bad_tag_at = -1;
   int          resp_err_at = -1;

   // Host model state
   int                 host_tick = 0;
   int                 host_last_due = 0;
   int                 host_due;
   int                 req_count = 0;
   int                 cpl_count = 0;
   ce_xfer_pkg::addr_t req_addr_q[$];
   ce_xfer_pkg::tag_t  req_tag_q[$];
   int                 req_due_q[$];

   // HPS model state
   int                 hps_tick = 0;
   int                 hps_last_due = 0;
   int                 hps_due;
   int                 wr_count = 0;
   int                 resp_count = 0;
   int                 resp_due_q[$];
   ce_xfer_pkg::word_t hps_mem[ce_xfer_pkg::addr_t];

   ce_top UUT (.*);

   always #4 clk = ~clk;

   // ------------------------------
   // Random source and host data
   // ------------------------------

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic int rand_bits(int n);
      int r;
      r = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         r = (r << 1) | int'(lfsr_q[0]);
      end
      return r;
   endfunction

   // Host memory contents as a function of the byte address
   function automatic ce_xfer_pkg::word_t fill_word(ce_xfer_pkg::addr_t a);
      logic [31:0]        s;
      ce_xfer_pkg::word_t w;
      s = a[31:0] ^ a[63:32] ^ 32'hc3a5_0f1e;
      w = '0;
      if (s == '0) s = 32'h1;
      for (int i = 0; i < 64; i++) begin
         s = lfsr_next(s);
         w = {w[62:0], s[0]};
      end
      return w;
   endfunction

   // ------------------------------
   // Bus models
   // ------------------------------

   always @(posedge clk) begin
      host_tick++;
      if (rdreq_valid && rdreq_ready) begin
         host_due = host_tick + 1 + rand_bits(2);
         if (host_due <= host_last_due) host_due = host_last_due + 1;
         host_last_due = host_due;
         req_addr_q.push_back(rdreq_addr);
         req_tag_q.push_back(rdreq_tag);
         req_due_q.push_back(host_due);
         req_count++;
      end
      #1;
      cpl_valid = 1'b0;
      cpl_err   = 1'b0;
      if (req_due_q.size() > 0 && req_due_q[0] <= host_tick) begin
         void'(req_due_q.pop_front());
         cpl_valid = 1'b1;
         cpl_data  = fill_word(req_addr_q.pop_front());
         cpl_tag   = req_tag_q.pop_front();
         if (cpl_count == bad_tag_at) cpl_tag = cpl_tag ^ 8'h5a;
         cpl_err   = (cpl_count == cpl_err_at);
         cpl_count++;
      end
   end

   always @(posedge clk) begin
      hps_tick++;
      if (wr_valid && wr_ready) begin
         hps_mem[wr_addr] = wr_data;
         hps_due = hps_tick + 1 + rand_bits(2) % 3;
         if (hps_due <= hps_last_due) hps_due = hps_last_due + 1;
         hps_last_due = hps_due;
         resp_due_q.push_back(hps_due);
         wr_count++;
      end
      #1;
      wr_resp_valid = 1'b0;
      wr_resp_err   = 1'b0;
      if (resp_due_q.size() > 0 && resp_due_q[0] <= hps_tick) begin
         void'(resp_due_q.pop_front());
         wr_resp_valid = 1'b1;
         wr_resp_err   = (resp_count == resp_err_at);
         resp_count++;
      end
   end

   always @(posedge clk) begin
      #1;
      rdreq_ready = stall_en ? rand_bits(1) != 0 : 1'b1;
      wr_ready    = stall_en ? rand_bits(1) != 0 : 1'b1;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("Timeout, run passed %0d cycles", CYCLE_LIMIT);
         $display("Finished with errors");
         $fatal(1);
      end
   end

   // ------------------------------
   // Checks and bus tasks
   // ------------------------------

   task automatic report_failure(string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_word(string name, ce_xfer_pkg::word_t exp, ce_xfer_pkg::word_t act);
      if (act !== exp) begin
         $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp, act);
         report_failure("data mismatch");
      end
   endtask

   task automatic check_status(ce_reg_pkg::status_t exp, ce_xfer_pkg::word_t act);
      if (act !== ce_xfer_pkg::word_t'(exp)) begin
         $display("ERROR at %0t: STATUS expected %h actual %h", $time, exp, act);
         report_failure("status mismatch");
      end
   endtask

   function automatic ce_reg_pkg::status_t make_status(logic done, logic cpl_e,
                                                       logic wr_e, logic tag_e);
      ce_reg_pkg::status_t s;
      s = '0;
      s.done    = done;
      s.cpl_err = cpl_e;
      s.wr_err  = wr_e;
      s.tag_err = tag_e;
      return s;
   endfunction

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic csr_write(ce_reg_pkg::csr_addr_e a, ce_xfer_pkg::word_t d);
      csr_wen   = 1'b1;
      csr_addr  = a;
      csr_wdata = d;
      step();
      csr_wen   = 1'b0;
   endtask

   task automatic csr_read(ce_reg_pkg::csr_addr_e a, output ce_xfer_pkg::word_t d);
      csr_ren  = 1'b1;
      csr_addr = a;
      step();
      csr_ren  = 1'b0;
      if (csr_rvalid !== 1'b1) report_failure("csr_rvalid missing one cycle after read");
      d = csr_rdata;
   endtask

   // Polls STATUS until done, returns the final status word
   task automatic wait_done(int size, output ce_xfer_pkg::word_t st);
      int guard;
      guard = 0;
      st = '0;
      while (st[1] !== 1'b1) begin
         csr_read(ce_reg_pkg::STATUS, st);
         guard++;
         if (guard > 60 * size + 200) report_failure("copy never signalled done");
      end
   endtask

   task automatic run_copy(ce_xfer_pkg::addr_t host, ce_xfer_pkg::addr_t hps, int size,
                           output ce_xfer_pkg::word_t st);
      int req0;
      int wr0;
      req0 = req_count;
      wr0  = wr_count;
      csr_write(ce_reg_pkg::HOST_ADDR, host);
      csr_write(ce_reg_pkg::HPS_ADDR, hps);
      csr_write(ce_reg_pkg::SIZE, ce_xfer_pkg::word_t'(size));
      csr_write(ce_reg_pkg::CTRL, 64'h1);
      wait_done(size, st);
      check_word("request count", ce_xfer_pkg::word_t'(size), ce_xfer_pkg::word_t'(req_count - req0));
      check_word("write count", ce_xfer_pkg::word_t'(size), ce_xfer_pkg::word_t'(wr_count - wr0));
      for (int i = 0; i < size; i++) begin
         if (!hps_mem.exists(hps + 8 * i)) report_failure("no write seen at an HPS address");
         check_word("hps_mem", fill_word(host + 8 * i), hps_mem[hps + 8 * i]);
      end
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------

   task automatic test_registers();
      ce_xfer_pkg::word_t d;
      csr_read(ce_reg_pkg::STATUS, d);
      check_status('0, d);
      csr_read(ce_reg_pkg::ID, d);
      // Version 1 in bits 15:12, feature 1 in bits 11:0
      check_word("ID", 64'h0000_0000_0000_1001, d);
      csr_write(ce_reg_pkg::HOST_ADDR, 64'h1234_5678_9abc_def0);
      csr_write(ce_reg_pkg::HPS_ADDR, 64'h0fed_cba9_8765_4320);
      csr_write(ce_reg_pkg::SIZE, 64'h0000_0000_0000_a5c3);
      csr_read(ce_reg_pkg::HOST_ADDR, d);
      check_word("HOST_ADDR", 64'h1234_5678_9abc_def0, d);
      csr_read(ce_reg_pkg::HPS_ADDR, d);
      check_word("HPS_ADDR", 64'h0fed_cba9_8765_4320, d);
      csr_read(ce_reg_pkg::SIZE, d);
      check_word("SIZE", 64'h0000_0000_0000_a5c3, d);
   endtask

   task automatic test_copies();
      ce_xfer_pkg::word_t st;
      run_copy(64'h0000_0010_0000_0000, 64'h0000_0020_0000_0000, 20, st);
      check_status(make_status(1, 0, 0, 0), st);
      stall_en = 1'b1;
      run_copy(64'h0000_0011_0000_1000, 64'h0000_0021_0000_1000, 37, st);
      check_status(make_status(1, 0, 0, 0), st);
      stall_en = 1'b0;
   endtask

   task automatic test_errors();
      ce_xfer_pkg::word_t st;
      cpl_err_at = cpl_count + 5;
      run_copy(64'h0000_0012_0000_0000, 64'h0000_0022_0000_0000, 12, st);
      check_status(make_status(1, 1, 0, 0), st);
      cpl_err_at = -1;
      bad_tag_at = cpl_count + 7;
      run_copy(64'h0000_0013_0000_0000, 64'h0000_0023_0000_0000, 12, st);
      check_status(make_status(1, 0, 0, 1), st);
      bad_tag_at  = -1;
      resp_err_at = resp_count + 3;
      run_copy(64'h0000_0014_0000_0000, 64'h0000_0024_0000_0000, 12, st);
      check_status(make_status(1, 0, 1, 0), st);
      resp_err_at = -1;
      run_copy(64'h0000_0015_0000_0000, 64'h0000_0025_0000_0000, 12, st);
      check_status(make_status(1, 0, 0, 0), st);
   endtask

   task automatic test_start_rules();
      ce_xfer_pkg::word_t st;
      int                 req0;
      int                 wr0;
      // Sticky error left set, so the empty start must clear it
      resp_err_at = resp_count;
      run_copy(64'h0000_0018_0000_0000, 64'h0000_0028_0000_0000, 4, st);
      check_status(make_status(1, 0, 1, 0), st);
      resp_err_at = -1;
      req0 = req_count;
      wr0  = wr_count;
      run_copy(64'h0000_0016_0000_0000, 64'h0000_0026_0000_0000, 0, st);
      check_status(make_status(1, 0, 0, 0), st);
      check_word("requests after empty copy", '0, ce_xfer_pkg::word_t'(req_count - req0));
      check_word("writes after empty copy", '0, ce_xfer_pkg::word_t'(wr_count - wr0));
      // Second start lands while the first copy is busy
      req0 = req_count;
      csr_write(ce_reg_pkg::HOST_ADDR, 64'h0000_0017_0000_0000);
      csr_write(ce_reg_pkg::HPS_ADDR, 64'h0000_0027_0000_0000);
      csr_write(ce_reg_pkg::SIZE, 64'd16);
      csr_write(ce_reg_pkg::CTRL, 64'h1);
      csr_write(ce_reg_pkg::SIZE, 64'd5);
      csr_write(ce_reg_pkg::CTRL, 64'h1);
      wait_done(16, st);
      check_status(make_status(1, 0, 0, 0), st);
      repeat (40) step();
      check_word("requests of busy copy", 64'd16, ce_xfer_pkg::word_t'(req_count - req0));
      for (int i = 0; i < 16; i++) begin
         check_word("hps_mem", fill_word(64'h0000_0017_0000_0000 + 8 * i),
                    hps_mem[64'h0000_0027_0000_0000 + 8 * i]);
      end
   endtask

   initial begin
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;
      step();
      test_registers();
      test_copies();
      test_errors();
      test_start_rules();
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: ce_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ce_cfg.svh"

module ce_top (
   input  logic                      clk,
   input  logic                      arst_n,

   // Register bus
   input  logic                      csr_wen,
   input  logic                      csr_ren,
   input  logic [`CE_CSR_ADDR_W-1:0] csr_addr,
   input  ce_xfer_pkg::word_t        csr_wdata,
   output ce_xfer_pkg::word_t        csr_rdata,
   output logic                      csr_rvalid,

   // Host read requests and completions
   output logic                      rdreq_valid,
   input  logic                      rdreq_ready,
   output ce_xfer_pkg::addr_t        rdreq_addr,
   output ce_xfer_pkg::tag_t         rdreq_tag,
   input  logic                      cpl_valid,
   input  ce_xfer_pkg::word_t        cpl_data,
   input  ce_xfer_pkg::tag_t         cpl_tag,
   input  logic                      cpl_err,

   // HPS writes and responses
   output logic                      wr_valid,
   input  logic                      wr_ready,
   output ce_xfer_pkg::addr_t        wr_addr,
   output ce_xfer_pkg::word_t        wr_data,
   input  logic                      wr_resp_valid,
   input  logic                      wr_resp_err
);

   ce_xfer_pkg::word_t buf_data;
   logic               buf_not_empty;
   logic               buf_pop;
   logic               first_tag_rst;
   logic               sts_cpl_err;
   logic               sts_tag_err;
   logic               sts_wr_err;
   logic               done;
   logic               busy;

   ce_cmd_if cmd ();

   ce_csr u_csr (
      .clk        (clk),
      .arst_n     (arst_n),
      .csr_wen    (csr_wen),
      .csr_ren    (csr_ren),
      .csr_addr   (ce_reg_pkg::csr_addr_e'(csr_addr)),
      .csr_wdata  (csr_wdata),
      .csr_rdata  (csr_rdata),
      .csr_rvalid (csr_rvalid),
      .cpl_err    (sts_cpl_err),
      .tag_err    (sts_tag_err),
      .wr_err     (sts_wr_err),
      .done       (done),
      .busy       (busy),
      .cmd        (cmd.csr)
   );

   ce_rd_req u_rd_req (
      .clk           (clk),
      .arst_n        (arst_n),
      .rdreq_ready   (rdreq_ready),
      .buf_pop       (buf_pop),
      .rdreq_valid   (rdreq_valid),
      .rdreq_addr    (rdreq_addr),
      .rdreq_tag     (rdreq_tag),
      .first_tag_rst (first_tag_rst),
      .cmd           (cmd.rd)
   );

   ce_cpl_rx u_cpl_rx (
      .clk           (clk),
      .arst_n        (arst_n),
      .first_tag_rst (first_tag_rst),
      .cpl_valid     (cpl_valid),
      .cpl_data      (cpl_data),
      .cpl_tag       (cpl_tag),
      .cpl_err_in    (cpl_err),
      .buf_pop       (buf_pop),
      .buf_data      (buf_data),
      .buf_not_empty (buf_not_empty),
      .cpl_err       (sts_cpl_err),
      .tag_err       (sts_tag_err)
   );

   ce_wr_eng u_wr_eng (
      .clk           (clk),
      .arst_n        (arst_n),
      .buf_data      (buf_data),
      .buf_not_empty (buf_not_empty),
      .wr_ready      (wr_ready),
      .wr_resp_valid (wr_resp_valid),
      .wr_resp_err   (wr_resp_err),
      .buf_pop       (buf_pop),
      .wr_valid      (wr_valid),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data),
      .wr_err        (sts_wr_err),
      .done          (done),
      .busy          (busy),
      .cmd           (cmd.wr)
   );

endmodule

`default_nettype wire

// File: ce_wr_eng.sv
`timescale 1ns/1ps
`default_nettype none

module ce_wr_eng (
   input  logic               clk,
   input  logic               arst_n,
   input  ce_xfer_pkg::word_t buf_data,
   input  logic               buf_not_empty,
   input  logic               wr_ready,
   input  logic               wr_resp_valid,
   input  logic               wr_resp_err,
   output logic               buf_pop,
   output logic               wr_valid,
   output ce_xfer_pkg::addr_t wr_addr,
   output ce_xfer_pkg::word_t wr_data,
   output logic               wr_err,
   output logic               done,
   output logic               busy,
   ce_cmd_if.wr               cmd
);

   ce_xfer_pkg::wr_state_e state;
   ce_xfer_pkg::size_t     wr_cnt;
   ce_xfer_pkg::size_t     resp_cnt;

   // Buffer head stays put until popped, so it is the write payload
   assign buf_pop = wr_valid && wr_ready;
   assign wr_addr = cmd.hps_addr + (ce_xfer_pkg::addr_t'(wr_cnt) << 3);
   assign wr_data = buf_data;

   // Responses may arrive before the last write leaves WRITE
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         resp_cnt <= '0;
         wr_err   <= 1'b0;
      end else if (cmd.start) begin
         resp_cnt <= '0;
         wr_err   <= 1'b0;
      end else if (wr_resp_valid) begin
         resp_cnt <= resp_cnt + 1'b1;
         if (wr_resp_err) begin
            wr_err <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= ce_xfer_pkg::WR_IDLE;
         wr_valid <= 1'b0;
         wr_cnt   <= '0;
         done     <= 1'b0;
         busy     <= 1'b0;
      end else begin
         case (state)
            ce_xfer_pkg::WR_IDLE: begin
               if (cmd.start) begin
                  wr_cnt <= '0;
                  // Empty transfer completes at once
                  done   <= (cmd.size == '0);
                  busy   <= (cmd.size != '0);
                  if (cmd.size != '0) begin
                     state <= ce_xfer_pkg::WR_WRITE;
                  end
               end
            end
            ce_xfer_pkg::WR_WRITE: begin
               if (buf_pop) begin
                  wr_valid <= 1'b0;
                  wr_cnt   <= wr_cnt + 1'b1;
                  if (wr_cnt + 1'b1 == cmd.size) begin
                     state <= ce_xfer_pkg::WR_DRAIN;
                  end
               end else if (buf_not_empty) begin
                  wr_valid <= 1'b1;
               end
            end
            ce_xfer_pkg::WR_DRAIN: begin
               if (resp_cnt == cmd.size) begin
                  done  <= 1'b1;
                  busy  <= 1'b0;
                  state <= ce_xfer_pkg::WR_IDLE;
               end
            end
            default: state <= ce_xfer_pkg::WR_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: ce_xfer_pkg.sv
`default_nettype none

`include "ce_cfg.svh"

package ce_xfer_pkg;

   typedef logic [`CE_DATA_W-1:0] word_t;
   typedef logic [`CE_ADDR_W-1:0] addr_t;
   typedef logic [`CE_SIZE_W-1:0] size_t;
   typedef logic [`CE_TAG_W-1:0]  tag_t;

   // Read request issuer
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ISSUE,
      RD_WAIT_CREDIT
   } rd_state_e;

   // Write engine
   typedef enum logic [1:0] {
      WR_IDLE,
      WR_WRITE,
      WR_DRAIN
   } wr_state_e;

endpackage

`default_nettype wire

// File: flist.f
+incdir+.
ce_reg_pkg.sv
ce_xfer_pkg.sv
ce_cmd_if.sv
ce_csr.sv
ce_rd_req.sv
ce_cpl_rx.sv
ce_wr_eng.sv
ce_top.sv
ce_chk.sv
ce_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the copy engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module ce_tb \
   -f flist.f \
   -o ce_sim

./obj_dir/ce_sim
